// File: word_to_byte.f
stream_pkg.sv
fifo_geom_pkg.sv
asym_fifo_mem.sv
asym_fifo.sv
byte_out_stage.sv
word_to_byte_top.sv
tb_clock_gen.sv
word_to_byte_asserts.sv
word_to_byte_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the word_to_byte testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f word_to_byte.f \
	--top-module word_to_byte_tb \
	--Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vword_to_byte_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: word_to_byte_tb.sv
`timescale 1ns/1ps
`default_nettype none

module word_to_byte_tb;

	localparam int DEPTH_LOG2  = 3;
	localparam int FIFO_WORDS  = 2 ** DEPTH_LOG2;
	localparam int MAX_PKT     = 6;
	localparam int A_PKTS      = 8;
	localparam int B_PKT_WORDS = 6;
	localparam int C_PKTS      = 40;
	// hang limit from the longest run the phases can produce
	localparam int MAX_WORDS       = (A_PKTS + C_PKTS) * MAX_PKT + 2 * B_PKT_WORDS;
	localparam int STALL_FACTOR    = 4;
	localparam int MARGIN          = 500;
	localparam int WATCHDOG_CYCLES = MAX_WORDS * 4 * STALL_FACTOR + MARGIN;

	localparam int READY_HIGH = 0;
	localparam int READY_LOW  = 1;
	localparam int READY_RAND = 2;

	typedef stream_pkg::byte_beat_t [3:0] beat_quad_t;

	logic                   clk;
	logic                   rst;
	logic                   in_valid;
	logic                   in_ready;
	stream_pkg::word_beat_t in_beat;
	logic                   out_valid;
	logic                   out_ready;
	stream_pkg::byte_beat_t out_beat;

	integer seed = 5;
	int ready_mode = READY_HIGH;
	int ready_draw = 0;
	int cycle_cnt = 0;
	int first_accept = 0;
	int words_sent = 0;
	int bytes_seen = 0;
	stream_pkg::byte_beat_t exp_q [$];

	tb_clock_gen #(
		.PERIOD_NS  (40),
		.RST_CYCLES (3)
	) u_clk (
		.clk (clk),
		.rst (rst)
	);

	word_to_byte_top #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_beat   (in_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_beat  (out_beat)
	);

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input stream_pkg::byte_t got,
			input stream_pkg::byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input string name, input stream_pkg::pkt_len_t got,
			input stream_pkg::pkt_len_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s got %0d cycles expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// four bytes, low byte first, length only on the final byte of a packet
	function automatic beat_quad_t expand_word(input stream_pkg::word_t data,
			input logic is_last, input int pkt_words);
		beat_quad_t quad;
		for (int i = 0; i < 4; i++) begin
			quad[i].data = data[8 * i +: 8];
			quad[i].last = is_last && (i == 3);
			quad[i].len  = quad[i].last ? stream_pkg::pkt_len_t'(4 * pkt_words) : '0;
		end
		return quad;
	endfunction

	function automatic int draw_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic send_word(input logic is_last, input int pkt_words, input int gap_pct);
		stream_pkg::word_t data;
		beat_quad_t        quad;
		while (draw_below(100) < gap_pct) begin
			@(negedge clk);
		end
		data = $random(seed);
		in_beat.data = data;
		in_beat.last = is_last;
		in_valid = 1'b1;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
		if (words_sent == 0) begin
			first_accept = cycle_cnt;
		end
		words_sent++;
		quad = expand_word(data, is_last, pkt_words);
		for (int i = 0; i < 4; i++) begin
			exp_q.push_back(quad[i]);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic send_packet(input int n_words, input int gap_pct);
		for (int i = 0; i < n_words; i++) begin
			send_word(i == n_words - 1, n_words, gap_pct);
		end
	endtask

	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		ready_mode = mode;
		@(negedge clk);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// with the output stalled, in_ready has to drop once the FIFO is full
	task automatic watch_full();
		int accepted;
		bit full_seen;
		accepted = 0;
		full_seen = 1'b0;
		while (!full_seen) begin
			@(posedge clk);
			if (in_valid && in_ready) begin
				accepted++;
			end else if (in_valid) begin
				full_seen = 1'b1;
			end
			if (accepted > FIFO_WORDS) begin
				$display("ERROR: in_ready still high after %0d words with output stalled",
					accepted);
				abort_run();
			end
		end
		repeat (FIFO_WORDS) begin
			@(posedge clk);
			if (in_ready) begin
				$display("ERROR: in_ready rose at %0t while the output was stalled", $time);
				abort_run();
			end
		end
		set_ready_mode(READY_HIGH);
	endtask

	task automatic compare_beat();
		stream_pkg::byte_beat_t exp_beat;
		if (exp_q.size() == 0) begin
			$display("ERROR: output beat at %0t while no byte was expected", $time);
			abort_run();
		end else begin
			exp_beat = exp_q.pop_front();
			if (bytes_seen == 0) begin
				check_cycles("first byte latency", cycle_cnt - first_accept, 2);
			end
			check_byte("out_beat.data", out_beat.data, exp_beat.data);
			check_flag("out_beat.last", out_beat.last, exp_beat.last);
			check_len("out_beat.len", out_beat.len, exp_beat.len);
			bytes_seen++;
		end
	endtask

	initial begin
		forever begin
			@(posedge clk);
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	// drawn on the rising edge, applied on the falling edge
	initial begin
		forever begin
			@(posedge clk);
			ready_draw = $random(seed);
		end
	end

	initial begin
		out_ready = 1'b1;
		forever begin
			@(negedge clk);
			case (ready_mode)
				READY_LOW:  out_ready = 1'b0;
				READY_RAND: out_ready = ($unsigned(ready_draw) % 100) < 60;
				default:    out_ready = 1'b1;
			endcase
		end
	end

	// monitor
	initial begin
		forever begin
			@(posedge clk);
			if (!rst && out_valid && out_ready) begin
				compare_beat();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, data stopped moving",
			WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		in_valid = 1'b0;
		in_beat  = '0;
		@(negedge rst);
		@(negedge clk);

		// back-to-back words, output always ready
		repeat (A_PKTS) begin
			send_packet(1 + draw_below(MAX_PKT), 0);
		end
		wait_drain();

		// stall the output until the FIFO fills, then release
		set_ready_mode(READY_LOW);
		fork
			begin
				send_packet(B_PKT_WORDS, 0);
				send_packet(B_PKT_WORDS, 0);
			end
			watch_full();
		join
		wait_drain();

		// random gaps on the input, random ready on the output
		set_ready_mode(READY_RAND);
		repeat (C_PKTS) begin
			send_packet(1 + draw_below(MAX_PKT), 30);
		end
		set_ready_mode(READY_HIGH);
		wait_drain();

		// a duplicated byte would still be in the two-stage pipeline
		repeat (4) @(negedge clk);
		if (out_valid || !in_ready) begin
			$display("ERROR: design still busy at %0t after the last expected byte", $time);
			abort_run();
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: word_to_byte_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module word_to_byte_asserts (
	input logic                   clk,
	input logic                   rst,
	input logic                   in_ready,
	input logic                   out_valid,
	input logic                   out_ready,
	input stream_pkg::byte_beat_t out_beat
);

	// a stalled output beat stays put until it transfers
	a_hold_when_stalled: assert property (
		@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> $stable(out_beat)
	) else $error("out_beat changed while out_valid was high and out_ready low");

	a_flags_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown({in_ready, out_valid})
	) else $error("in_ready or out_valid is unknown after reset");

	// len rides only on the final byte
	a_len_with_last: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> ((out_beat.len != '0) == out_beat.last)
	) else $error("out_beat.len and out_beat.last disagree");

endmodule

bind word_to_byte_top word_to_byte_asserts u_asserts (
	.clk       (clk),
	.rst       (rst),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_beat  (out_beat)
);

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// reset drops on a falling edge, away from the active edge
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: word_to_byte_top.sv
`timescale 1ns/1ps
`default_nettype none

module word_to_byte_top #(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  stream_pkg::word_beat_t in_beat,
	output logic                   out_valid,
	input  logic                   out_ready,
	output stream_pkg::byte_beat_t out_beat
);

	// byte stream between FIFO and output register
	logic                   rd_valid;
	logic                   rd_ready;
	stream_pkg::byte_beat_t rd_beat;

	asym_fifo #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_fifo (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_beat  (in_beat),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready),
		.rd_beat  (rd_beat)
	);

	// adds one cycle and fills in packet length
	byte_out_stage u_out (
		.clk       (clk),
		.rst       (rst),
		.rd_valid  (rd_valid),
		.rd_ready  (rd_ready),
		.rd_beat   (rd_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_beat  (out_beat)
	);

endmodule

`default_nettype wire

// File: byte_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module byte_out_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_valid,
	output logic                   rd_ready,
	input  stream_pkg::byte_beat_t rd_beat,
	output logic                   out_valid,
	input  logic                   out_ready,
	output stream_pkg::byte_beat_t out_beat
);

	stream_pkg::pkt_len_t pkt_cnt;
	stream_pkg::pkt_len_t pkt_cnt_inc;
	logic                 load;

	// take a byte when empty or when the held one leaves this cycle
	assign rd_ready = !out_valid || out_ready;
	assign load     = rd_valid && rd_ready;

	assign pkt_cnt_inc = pkt_cnt + stream_pkg::pkt_len_t'(1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// running count of bytes in the current packet
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pkt_cnt <= '0;
		end else if (load) begin
			if (rd_beat.last) begin
				pkt_cnt <= '0;
			end else begin
				pkt_cnt <= pkt_cnt_inc;
			end
		end
	end

	// payload register
	always_ff @(posedge clk) begin
		if (load) begin
			out_beat.data <= rd_beat.data;
			out_beat.last <= rd_beat.last;
			// length only rides on the final byte
			out_beat.len  <= rd_beat.last ? pkt_cnt_inc : '0;
		end
	end

endmodule

`default_nettype wire

// File: asym_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module asym_fifo #(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  stream_pkg::word_beat_t in_beat,
	output logic                   rd_valid,
	input  logic                   rd_ready,
	output stream_pkg::byte_beat_t rd_beat
);

	localparam int SEL_W    = fifo_geom_pkg::BYTE_SEL_W;
	localparam int RD_PTR_W = DEPTH_LOG2 + SEL_W;
	// one extra bit so a completely full FIFO can be counted
	localparam int OCC_W    = RD_PTR_W + 1;
	localparam int CAP      = 2 ** RD_PTR_W;

	localparam logic [OCC_W-1:0] CAP_BYTES  = OCC_W'(CAP);
	localparam logic [OCC_W-1:0] WORD_BYTES = OCC_W'(fifo_geom_pkg::BYTES_PER_WORD);
	localparam logic [SEL_W-1:0] LAST_LANE  = SEL_W'(fifo_geom_pkg::BYTES_PER_WORD - 1);

	logic [DEPTH_LOG2-1:0]      wr_ptr;
	logic [RD_PTR_W-1:0]        rd_ptr;
	logic [OCC_W-1:0]           occ_bytes;
	logic [OCC_W-1:0]           free_bytes;
	logic                       wr_fire;
	logic                       rd_fire;
	fifo_geom_pkg::fifo_entry_t wr_entry;
	logic [DEPTH_LOG2-1:0]      rd_addr;
	logic [SEL_W-1:0]           rd_sel;
	stream_pkg::byte_t          mem_byte;
	logic                       mem_last;

	// flags come from the byte count alone
	assign free_bytes = CAP_BYTES - occ_bytes;
	assign in_ready   = (free_bytes >= WORD_BYTES);
	assign rd_valid   = (occ_bytes != '0);

	assign wr_fire = in_valid && in_ready;
	assign rd_fire = rd_valid && rd_ready;

	// upper bits pick the word, lower bits the lane
	assign rd_addr = rd_ptr[RD_PTR_W-1:SEL_W];
	assign rd_sel  = rd_ptr[SEL_W-1:0];

	assign wr_entry = '{data: in_beat.data, last: in_beat.last};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_fire) begin
			wr_ptr <= wr_ptr + DEPTH_LOG2'(1);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (rd_fire) begin
			rd_ptr <= rd_ptr + RD_PTR_W'(1);
		end
	end

	// a write and a read in the same cycle both count
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			occ_bytes <= '0;
		end else if (wr_fire || rd_fire) begin
			occ_bytes <= occ_bytes + (wr_fire ? WORD_BYTES : '0) - OCC_W'(rd_fire);
		end
	end

	asym_fifo_mem #(
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_mem (
		.clk      (clk),
		.wr_en    (wr_fire),
		.wr_addr  (wr_ptr),
		.wr_entry (wr_entry),
		.rd_addr  (rd_addr),
		.rd_sel   (rd_sel),
		.rd_data  (mem_byte),
		.rd_last  (mem_last)
	);

	// end of packet only on the top lane of a last word
	always_comb begin
		rd_beat      = '0;
		rd_beat.data = mem_byte;
		rd_beat.last = mem_last && (rd_sel == LAST_LANE);
		// length is filled in by the output stage
		rd_beat.len  = '0;
	end

endmodule

`default_nettype wire

// File: asym_fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

module asym_fifo_mem #(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                                 clk,
	input  logic                                 wr_en,
	input  logic [DEPTH_LOG2-1:0]                wr_addr,
	input  fifo_geom_pkg::fifo_entry_t           wr_entry,
	input  logic [DEPTH_LOG2-1:0]                rd_addr,
	input  logic [fifo_geom_pkg::BYTE_SEL_W-1:0] rd_sel,
	output stream_pkg::byte_t                    rd_data,
	output logic                                 rd_last
);

	localparam int DEPTH  = 2 ** DEPTH_LOG2;
	localparam int BYTE_W = $bits(stream_pkg::byte_t);

	fifo_geom_pkg::fifo_entry_t mem [DEPTH];
	fifo_geom_pkg::fifo_entry_t rd_entry;

	// write side takes a whole word per edge
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_entry;
		end
	end

	// read side is asynchronous
	assign rd_entry = mem[rd_addr];

	// lane 0 sits in the low bits
	assign rd_data = rd_entry.data[rd_sel * BYTE_W +: BYTE_W];
	assign rd_last = rd_entry.last;

endmodule

`default_nettype wire

// File: fifo_geom_pkg.sv
`default_nettype none

package fifo_geom_pkg;

	// lanes per stored word, follows from the stream types
	localparam int BYTES_PER_WORD = $bits(stream_pkg::word_t) / $bits(stream_pkg::byte_t);

	// byte lane selector within a word
	localparam int BYTE_SEL_W = $clog2(BYTES_PER_WORD);

	// one memory entry, 33 bits
	// last is kept per word and only shown on the top lane
	typedef struct packed {
		stream_pkg::word_t data;
		logic              last;
	} fifo_entry_t;

endpackage

`default_nettype wire

// File: stream_pkg.sv
`default_nettype none

package stream_pkg;

	// one wide input word
	typedef logic [31:0] word_t;

	// one narrow output byte
	typedef logic [7:0] byte_t;

	// packet length in bytes
	// sized well above the longest packet the source sends
	typedef logic [15:0] pkt_len_t;

	// input beat, 33 bits
	// last marks the final word of a packet
	typedef struct packed {
		word_t data;
		logic  last;
	} word_beat_t;

	// output beat, 25 bits
	typedef struct packed {
		byte_t    data;
		// set on the final byte of a packet only
		logic     last;
		// byte count of the packet on the last beat, zero otherwise
		pkt_len_t len;
	} byte_beat_t;

endpackage

`default_nettype wire
